/* dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address split
`define DC_XLEN          32
`define DC_BO            3     // byte offset inside a line
`define DC_IDX_BITS      5
`define DC_TAG_BITS      24    // XLEN - IDX_BITS - BO

// line array
`define DC_BLOCK_BITS    64
`define DC_N_LINES       32

// miss table
`define DC_N_MSHR        4

// memory port tag, zero means no tag
`define DC_MEM_TAG_BITS  4

`endif

/* dcache_pkg.sv */
`default_nettype none
`include "dcache_defs.svh"

package dcache_pkg;

    typedef enum logic [1:0] {READY, WAIT_MSHR, WAIT} dc_state_t;
    typedef enum logic {MEM_READ, MEM_WRITE} mem_op_t;
    typedef enum logic [1:0] {BYTE, HALF, WORD} mem_size_t;
    typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} bus_cmd_t;

    typedef logic [`DC_XLEN-1:0]        addr_t;
    typedef logic [`DC_XLEN-`DC_BO-1:0] line_addr_t;  // address without its offset
    typedef logic [`DC_BLOCK_BITS-1:0]  block_t;
    typedef logic [`DC_MEM_TAG_BITS-1:0] mem_tag_t;

    // zero-extended lane of a block
    function automatic logic [31:0] lane_extract(block_t blk, mem_size_t size,
                                                 logic [`DC_BO-1:0] off);
        logic [31:0] lane;
        lane = '0;
        case (size)
            BYTE: lane[7:0]  = blk[{off, 3'b000} +: 8];
            HALF: lane[15:0] = blk[{off[2:1], 4'b0000} +: 16];  // half ignores offset bit 0
            WORD: lane       = blk[{off[2], 5'b00000} +: 32];
            default: lane = '0;
        endcase
        return lane;
    endfunction

    // write a store lane into a block
    function automatic block_t lane_merge(block_t blk, mem_size_t size,
                                          logic [`DC_BO-1:0] off, logic [31:0] wdata);
        block_t res;
        res = blk;
        case (size)
            BYTE: res[{off, 3'b000} +: 8]         = wdata[7:0];
            HALF: res[{off[2:1], 4'b0000} +: 16]  = wdata[15:0];
            WORD: res[{off[2], 5'b00000} +: 32]   = wdata;
            default: res = blk;
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

/* dcache_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// request lookup into the line array
interface lookup_if;
    import dcache_pkg::*;

    logic        commit;     // request finishes this cycle
    mem_op_t     op;
    mem_size_t   size;
    addr_t       addr;
    logic [31:0] wdata;
    logic        hit;
    block_t      hit_block;

    modport ctrl_mp  (output commit, op, size, addr, wdata, input hit, hit_block);
    modport lines_mp (input commit, op, size, addr, wdata, output hit, hit_block);
endinterface

// line install from the miss table, one cycle
interface fill_if;
    import dcache_pkg::*;

    logic       valid;
    line_addr_t line_addr;
    block_t     block;

    modport mshr_mp  (output valid, line_addr, block);
    modport lines_mp (input valid, line_addr, block);
    modport ctrl_mp  (input valid, line_addr, block);
endinterface

// dirty victim leaving the line array
interface evict_if;
    import dcache_pkg::*;

    logic       valid;
    line_addr_t line_addr;
    block_t     block;

    modport lines_mp (output valid, line_addr, block);
    modport mshr_mp  (input valid, line_addr, block);
endinterface

`default_nettype wire

/* dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req_valid,
    input  dcache_pkg::mem_op_t   req_op,
    input  dcache_pkg::mem_size_t req_size,
    input  dcache_pkg::addr_t     req_addr,
    input  logic [31:0]           req_wdata,
    lookup_if.ctrl_mp             lk,
    fill_if.ctrl_mp               fill,
    input  logic                  fwd_hit,
    input  logic                  has_free,
    output logic                  alloc,
    output logic                  take_fwd,
    output dcache_pkg::addr_t     miss_addr,
    output logic                  stall,
    output logic                  resp_valid,
    output logic [31:0]           resp_data
);
    import dcache_pkg::*;

    dc_state_t   state, next_state;
    mem_op_t     held_op;
    mem_size_t   held_size;
    addr_t       held_addr;
    logic [31:0] held_wdata;
    logic        in_ready;
    logic        act_valid;
    logic        finish;
    block_t      src_block;   // line the request finishes on
    block_t      res_block;

    assign in_ready  = (state == READY);
    assign act_valid = in_ready ? req_valid : 1'b1;  // held request is always live

    assign lk.op     = in_ready ? req_op    : held_op;
    assign lk.size   = in_ready ? req_size  : held_size;
    assign lk.addr   = in_ready ? req_addr  : held_addr;
    assign lk.wdata  = in_ready ? req_wdata : held_wdata;
    assign lk.commit = finish;
    assign miss_addr = lk.addr;
    assign stall     = !in_ready;

    always_comb begin
        next_state = state;
        finish     = 1'b0;
        alloc      = 1'b0;
        take_fwd   = 1'b0;
        src_block  = lk.hit_block;
        case (state)
            READY, WAIT_MSHR: begin
                if (act_valid) begin
                    if (lk.hit) begin
                        finish     = 1'b1;
                        next_state = READY;
                    end else if (has_free && fwd_hit) begin
                        take_fwd   = 1'b1;  // line comes back from a waiting write-back
                        finish     = 1'b1;
                        src_block  = fill.block;
                        next_state = READY;
                    end else if (has_free) begin
                        alloc      = 1'b1;
                        next_state = WAIT;
                    end else begin
                        next_state = WAIT_MSHR;
                    end
                end
            end
            WAIT: begin
                if (fill.valid && fill.line_addr == held_addr[`DC_XLEN-1:`DC_BO]) begin
                    finish     = 1'b1;
                    src_block  = fill.block;
                    next_state = READY;
                end
            end
            default: next_state = READY;
        endcase
    end

    // stores report the merged lane
    assign res_block = (lk.op == MEM_WRITE) ?
                       lane_merge(src_block, lk.size, lk.addr[`DC_BO-1:0], lk.wdata) : src_block;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= READY;
            resp_valid <= 1'b0;
        end else begin
            state      <= next_state;
            resp_valid <= finish;
        end
    end

    always_ff @(posedge clock) begin
        if (in_ready && req_valid) begin
            held_op    <= req_op;
            held_size  <= req_size;
            held_addr  <= req_addr;
            held_wdata <= req_wdata;
        end
        resp_data <= lane_extract(res_block, lk.size, lk.addr[`DC_BO-1:0]);
    end

endmodule

`default_nettype wire

/* dcache_lines.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_lines (
    input logic        clock,
    input logic        reset,
    lookup_if.lines_mp lk,
    fill_if.lines_mp   fill,
    evict_if.lines_mp  evict
);
    import dcache_pkg::*;

    logic [`DC_N_LINES-1:0]  valid_q;
    logic [`DC_N_LINES-1:0]  dirty_q;
    logic [`DC_TAG_BITS-1:0] tag_q  [`DC_N_LINES];
    block_t                  data_q [`DC_N_LINES];

    logic [`DC_IDX_BITS-1:0] l_idx, f_idx, wr_idx;
    logic [`DC_TAG_BITS-1:0] l_tag, f_tag, wr_tag;
    logic                    wr_en;
    logic                    wr_dirty;
    block_t                  wr_block;
    logic                    st_fill;   // committed store lands in the installed line

    assign l_idx = lk.addr[`DC_BO +: `DC_IDX_BITS];
    assign l_tag = lk.addr[`DC_XLEN-1 -: `DC_TAG_BITS];
    assign f_idx = fill.line_addr[`DC_IDX_BITS-1:0];
    assign f_tag = fill.line_addr[`DC_XLEN-`DC_BO-1 -: `DC_TAG_BITS];

    assign lk.hit       = valid_q[l_idx] && (tag_q[l_idx] == l_tag);
    assign lk.hit_block = data_q[l_idx];

    assign st_fill = lk.commit && (lk.op == MEM_WRITE)
                     && (lk.addr[`DC_XLEN-1:`DC_BO] == fill.line_addr);

    // only a dirty victim goes back to memory
    assign evict.valid     = fill.valid && valid_q[f_idx] && dirty_q[f_idx];
    assign evict.line_addr = {tag_q[f_idx], f_idx};
    assign evict.block     = data_q[f_idx];

    always_comb begin
        wr_en    = 1'b0;
        wr_idx   = l_idx;
        wr_tag   = l_tag;
        wr_dirty = 1'b1;
        wr_block = data_q[l_idx];
        if (fill.valid) begin
            wr_en    = 1'b1;
            wr_idx   = f_idx;
            wr_tag   = f_tag;
            wr_dirty = st_fill;  // clean unless a store rides along
            wr_block = st_fill ?
                       lane_merge(fill.block, lk.size, lk.addr[`DC_BO-1:0], lk.wdata) :
                       fill.block;
        end else if (lk.commit && lk.hit && lk.op == MEM_WRITE) begin
            wr_en    = 1'b1;
            wr_block = lane_merge(data_q[l_idx], lk.size, lk.addr[`DC_BO-1:0], lk.wdata);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
            dirty_q[wr_idx] <= wr_dirty;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            tag_q[wr_idx]  <= wr_tag;
            data_q[wr_idx] <= wr_block;
        end
    end

endmodule

`default_nettype wire

/* dcache_mshr.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_mshr (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  alloc,
    input  logic                  take_fwd,
    input  dcache_pkg::addr_t     miss_addr,
    output logic                  fwd_hit,
    output logic                  has_free,
    fill_if.mshr_mp               fill,
    evict_if.mshr_mp              evict,
    output dcache_pkg::bus_cmd_t  mem_command,
    output dcache_pkg::addr_t     mem_addr,
    output dcache_pkg::block_t    mem_data,
    input  dcache_pkg::mem_tag_t  mem_response,
    input  dcache_pkg::mem_tag_t  mem_tag,
    input  dcache_pkg::block_t    mem_rdata
);
    import dcache_pkg::*;

    localparam int IW = $clog2(`DC_N_MSHR);

    logic [`DC_N_MSHR-1:0] valid_q, valid_n;
    mem_op_t               op_q    [`DC_N_MSHR];
    mem_op_t               op_n    [`DC_N_MSHR];
    mem_tag_t              tag_q   [`DC_N_MSHR];   // zero while not yet issued
    mem_tag_t              tag_n   [`DC_N_MSHR];
    line_addr_t            line_q  [`DC_N_MSHR];
    line_addr_t            line_n  [`DC_N_MSHR];
    block_t                block_q [`DC_N_MSHR];
    block_t                block_n [`DC_N_MSHR];

    logic [IW-1:0] iss_idx, rsp_idx, fwd_idx;
    logic          iss_any, rsp_hit;

    always_comb begin
        logic          wr_found;
        logic [IW-1:0] wr_idx;
        wr_found = 1'b0;
        wr_idx   = '0;
        iss_any  = 1'b0;
        iss_idx  = '0;
        rsp_hit  = 1'b0;
        rsp_idx  = '0;
        fwd_hit  = 1'b0;
        fwd_idx  = '0;
        for (int i = `DC_N_MSHR-1; i >= 0; i--) begin  // descending so lowest index wins
            if (valid_q[i] && tag_q[i] == '0) begin
                iss_any = 1'b1;
                iss_idx = IW'(i);
                if (op_q[i] == MEM_WRITE) begin
                    wr_found = 1'b1;
                    wr_idx   = IW'(i);
                end
            end
            if (valid_q[i] && op_q[i] == MEM_READ && mem_tag != '0 && tag_q[i] == mem_tag) begin
                rsp_hit = 1'b1;
                rsp_idx = IW'(i);
            end
            if (valid_q[i] && op_q[i] == MEM_WRITE
                && line_q[i] == miss_addr[`DC_XLEN-1:`DC_BO]) begin
                fwd_hit = 1'b1;
                fwd_idx = IW'(i);
            end
        end
        if (wr_found) iss_idx = wr_idx;  // stores go out first
    end

    assign has_free    = !(&valid_q);
    assign mem_command = !iss_any ? BUS_NONE :
                         (op_q[iss_idx] == MEM_WRITE) ? BUS_STORE : BUS_LOAD;
    assign mem_addr    = {line_q[iss_idx], {`DC_BO{1'b0}}};
    assign mem_data    = block_q[iss_idx];

    // memory data wins, the forward case only happens with no read in flight
    assign fill.valid     = rsp_hit || take_fwd;
    assign fill.line_addr = rsp_hit ? line_q[rsp_idx] : line_q[fwd_idx];
    assign fill.block     = rsp_hit ? mem_rdata : block_q[fwd_idx];

    always_comb begin
        logic          found;
        logic [IW-1:0] slot;
        valid_n = valid_q;
        op_n    = op_q;
        tag_n   = tag_q;
        line_n  = line_q;
        block_n = block_q;
        if (iss_any && mem_response != '0) begin
            if (op_q[iss_idx] == MEM_WRITE) valid_n[iss_idx] = 1'b0;  // store done once accepted
            else tag_n[iss_idx] = mem_response;
        end
        if (rsp_hit) valid_n[rsp_idx] = 1'b0;
        found = 1'b0;
        slot  = '0;
        for (int i = `DC_N_MSHR-1; i >= 0; i--) begin
            if (!valid_n[i]) begin
                found = 1'b1;
                slot  = IW'(i);
            end
        end
        if (alloc && found) begin
            valid_n[slot] = 1'b1;
            op_n[slot]    = MEM_READ;
            tag_n[slot]   = '0;
            line_n[slot]  = miss_addr[`DC_XLEN-1:`DC_BO];
        end
        if (evict.valid) begin
            found = 1'b0;
            for (int i = `DC_N_MSHR-1; i >= 0; i--) begin
                if (!valid_n[i]) begin
                    found = 1'b1;
                    slot  = IW'(i);
                end
            end
            // a waiting write-back of the same line just takes the newer data
            for (int i = `DC_N_MSHR-1; i >= 0; i--) begin
                if (valid_n[i] && op_n[i] == MEM_WRITE && line_n[i] == evict.line_addr) begin
                    found = 1'b1;
                    slot  = IW'(i);
                end
            end
            if (found) begin
                valid_n[slot] = 1'b1;
                op_n[slot]    = MEM_WRITE;
                tag_n[slot]   = '0;
                line_n[slot]  = evict.line_addr;
                block_n[slot] = evict.block;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) valid_q <= '0;
        else       valid_q <= valid_n;
    end

    always_ff @(posedge clock) begin
        op_q    <= op_n;
        tag_q   <= tag_n;
        line_q  <= line_n;
        block_q <= block_n;
    end

endmodule

`default_nettype wire

/* dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req_valid,
    input  dcache_pkg::mem_op_t   req_op,
    input  dcache_pkg::mem_size_t req_size,
    input  dcache_pkg::addr_t     req_addr,
    input  logic [31:0]           req_wdata,
    output logic                  stall,
    output logic                  resp_valid,
    output logic [31:0]           resp_data,
    output dcache_pkg::bus_cmd_t  mem_command,
    output dcache_pkg::addr_t     mem_addr,
    output dcache_pkg::block_t    mem_data,
    input  dcache_pkg::mem_tag_t  mem_response,
    input  dcache_pkg::mem_tag_t  mem_tag,
    input  dcache_pkg::block_t    mem_rdata
);
    import dcache_pkg::*;

    logic  alloc;
    logic  take_fwd;
    logic  fwd_hit;
    logic  has_free;
    addr_t miss_addr;

    lookup_if lk_if ();
    fill_if   fill_bus ();
    evict_if  evict_bus ();

    dcache_ctrl u_ctrl (
        .clock      (clock),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_size   (req_size),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .lk         (lk_if.ctrl_mp),
        .fill       (fill_bus.ctrl_mp),
        .fwd_hit    (fwd_hit),
        .has_free   (has_free),
        .alloc      (alloc),
        .take_fwd   (take_fwd),
        .miss_addr  (miss_addr),
        .stall      (stall),
        .resp_valid (resp_valid),
        .resp_data  (resp_data)
    );

    dcache_lines u_lines (
        .clock (clock),
        .reset (reset),
        .lk    (lk_if.lines_mp),
        .fill  (fill_bus.lines_mp),
        .evict (evict_bus.lines_mp)
    );

    dcache_mshr u_mshr (
        .clock        (clock),
        .reset        (reset),
        .alloc        (alloc),
        .take_fwd     (take_fwd),
        .miss_addr    (miss_addr),
        .fwd_hit      (fwd_hit),
        .has_free     (has_free),
        .fill         (fill_bus.mshr_mp),
        .evict        (evict_bus.mshr_mp),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_rdata    (mem_rdata)
    );

endmodule

`default_nettype wire

/* tb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 hold_stores,    // refuse every store while high
    input  dcache_pkg::bus_cmd_t mem_command,
    input  dcache_pkg::addr_t    mem_addr,
    input  dcache_pkg::block_t   mem_data,
    output dcache_pkg::mem_tag_t mem_response,
    output dcache_pkg::mem_tag_t mem_tag,
    output dcache_pkg::block_t   mem_rdata
);
    import dcache_pkg::*;

    block_t      backing [64];    // the 512-byte test window
    logic        accept_now;
    logic [15:0] tag_busy;        // bit 0 never used
    mem_tag_t    free_tag;
    integer      seed;
    int          now;
    int          found;
    logic        in_reset;
    mem_tag_t    acc_tag;
    mem_tag_t    ret_tag;
    bus_cmd_t    acc_cmd;
    addr_t       acc_addr;
    block_t      acc_data;

    // loads in flight
    mem_tag_t pend_tag  [$];
    int       pend_due  [$];
    block_t   pend_data [$];

    initial begin
        seed       = 35;
        now        = 0;
        in_reset   = 1'b1;
        accept_now = 1'b0;
        tag_busy   = '0;
        mem_tag    = '0;
        mem_rdata  = '0;
        acc_tag    = '0;
        ret_tag    = '0;
        // byte value depends on every address bit
        for (int a = 0; a < 512; a++) begin
            backing[a / 8][(a % 8) * 8 +: 8] = 8'(a * 29 + (a >> 7) * 71 + 8'h3c);
        end
    end

    always_comb begin
        free_tag = '0;
        for (int t = 15; t >= 1; t--) begin
            if (!tag_busy[t]) free_tag = mem_tag_t'(t);
        end
    end

    assign mem_response = (mem_command == BUS_NONE || !accept_now
                           || (mem_command == BUS_STORE && hold_stores)) ? '0 : free_tag;

    // bus values are steady at the falling edge
    always @(negedge clock) begin
        in_reset = reset;
        acc_tag  = mem_response;
        acc_cmd  = mem_command;
        acc_addr = mem_addr;
        acc_data = mem_data;
        ret_tag  = mem_tag;
    end

    always @(posedge clock) begin
        #5;
        if (in_reset) begin
            pend_tag.delete();
            pend_due.delete();
            pend_data.delete();
            tag_busy   = '0;
            mem_tag    = '0;
            accept_now = 1'b0;
            acc_tag    = '0;
            ret_tag    = '0;
        end else begin
            now++;
            if (ret_tag != '0) tag_busy[ret_tag] = 1'b0;  // response taken at this edge
            if (acc_tag != '0 && acc_cmd == BUS_STORE) begin
                backing[acc_addr[8:3]] = acc_data;
            end else if (acc_tag != '0 && acc_cmd == BUS_LOAD) begin
                tag_busy[acc_tag] = 1'b1;
                pend_tag.push_back(acc_tag);
                pend_due.push_back(now + 1 + int'($unsigned($random(seed)) % 5));
                pend_data.push_back(backing[acc_addr[8:3]]);
            end
            mem_tag = '0;
            found   = -1;
            for (int i = pend_tag.size() - 1; i >= 0; i--) begin
                if (pend_due[i] <= now) found = i;  // oldest due load goes first
            end
            if (found >= 0) begin
                mem_tag   = pend_tag[found];
                mem_rdata = pend_data[found];
                pend_tag.delete(found);
                pend_due.delete(found);
                pend_data.delete(found);
            end
            accept_now = ($unsigned($random(seed)) % 4) != 0;
        end
    end

endmodule

`default_nettype wire

/* tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int N_PAIRS = 8;
    localparam int N_RAND  = 200;
    localparam int N_HOLD  = 160;
    localparam int N_SWEEP = 128;
    localparam int N_REQ   = 2 * N_PAIRS + N_RAND + N_HOLD + N_SWEEP;
    localparam int LIMIT   = 400 * N_REQ + 100;

    logic        clock;
    logic        reset;
    logic        req_valid;
    mem_op_t     req_op;
    mem_size_t   req_size;
    addr_t       req_addr;
    logic [31:0] req_wdata;
    logic        stall;
    logic        resp_valid;
    logic [31:0] resp_data;
    bus_cmd_t    mem_command;
    addr_t       mem_addr;
    block_t      mem_data;
    mem_tag_t    mem_response;
    mem_tag_t    mem_tag;
    block_t      mem_rdata;
    logic        hold_stores;
    logic        hold_enable;

    logic [7:0]  gold [512];      // program view of the window
    logic        res_valid [32];  // lines the cache must hold now
    logic [5:0]  res_line [32];
    logic        res_dirty [32];
    logic        wb_valid [64];   // write-backs waiting in the miss table
    block_t      wb_block [64];
    logic [5:0]  cur_line;
    block_t      cur_pre_block;   // line before the current store
    integer      seed;
    int          cycle;
    int          n_pass;
    int          n_fail;
    int          n_fwd;

    dcache_top u_dcache_top (
        .clock        (clock),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_op       (req_op),
        .req_size     (req_size),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .stall        (stall),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_rdata    (mem_rdata)
    );

    tb_mem_model u_mem (
        .clock        (clock),
        .reset        (reset),
        .hold_stores  (hold_stores),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_rdata    (mem_rdata)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        repeat (LIMIT) @(posedge clock);
        $display("timeout: run still busy after %0d cycles", LIMIT);
        $display("Verification failed");
        $finish;
    end

    always @(posedge clock) cycle <= cycle + 1;

    always @(posedge clock) begin
        #5 hold_stores = hold_enable && (cycle % 48 < 32);  // stores refused in bursts
    end

    task automatic check_load_data(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        if (act === exp) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_state_bits(input logic exp_stall, input logic exp_resp);
        if (stall === exp_stall && resp_valid === exp_resp) begin
            n_pass++;
        end else begin
            n_fail++;
            if (stall !== exp_stall)
                $display("CHECK FAILED at %0t: stall expected %b, got %b",
                         $time, exp_stall, stall);
            if (resp_valid !== exp_resp)
                $display("CHECK FAILED at %0t: resp_valid expected %b, got %b",
                         $time, exp_resp, resp_valid);
        end
    endtask

    task automatic check_bus_cmd(input bus_cmd_t exp, input bus_cmd_t act);
        if (act === exp) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("CHECK FAILED at %0t: mem_command expected %0d, got %0d", $time, exp, act);
        end
    endtask

    task automatic check_block(input string name, input block_t exp, input block_t act);
        if (act === exp) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    function automatic block_t gold_block(input logic [5:0] line);
        block_t blk;
        for (int i = 0; i < 8; i++) blk[i * 8 +: 8] = gold[{line, 3'(i)}];
        return blk;
    endfunction

    function automatic int waiting_writebacks();
        int n;
        n = 0;
        for (int i = 0; i < 64; i++) begin
            if (wb_valid[i]) n++;
        end
        return n;
    endfunction

    // bus traffic, checked where it is stable
    always @(negedge clock) begin
        block_t     exp;
        logic [5:0] bus_line;
        bus_line = mem_addr[8:3];
        if (!reset && mem_command != BUS_NONE && mem_response != '0) begin
            if (mem_command == BUS_STORE) begin
                if (mem_addr[31:9] != '0 || mem_addr[2:0] != '0) begin
                    n_fail++;
                    $display("[%0t] write-back address %h is not a line of the test window",
                             $time, mem_addr);
                end else if (!wb_valid[bus_line]) begin
                    n_fail++;
                    $display("[%0t] write-back of line %h with no dirty line evicted there",
                             $time, bus_line);
                end else begin
                    check_block("mem_data", wb_block[bus_line], mem_data);
                    wb_valid[bus_line] = 1'b0;
                end
            end else begin
                exp = (bus_line == cur_line) ? cur_pre_block : gold_block(bus_line);
                check_block("memory line at load", exp, u_mem.backing[bus_line]);
            end
        end
    end

    // halves and words ignore the low offset bits
    task automatic apply_golden(input mem_op_t op, input mem_size_t size, input logic [8:0] a,
                                input logic [31:0] wd, output logic [31:0] exp);
        int         nbytes;
        logic [8:0] base;
        nbytes        = (size == BYTE) ? 1 : (size == HALF) ? 2 : 4;
        base          = a & ~9'(nbytes - 1);
        cur_line      = a[8:3];
        cur_pre_block = gold_block(a[8:3]);
        if (op == MEM_WRITE) begin
            for (int i = 0; i < nbytes; i++) gold[base + 9'(i)] = wd[i * 8 +: 8];
        end
        exp = '0;
        for (int i = 0; i < nbytes; i++) exp[i * 8 +: 8] = gold[base + 9'(i)];
    endtask

    task automatic do_request(input mem_op_t op, input mem_size_t size, input logic [8:0] a,
                              input logic [31:0] wd);
        logic        resident;
        logic        fwd_now;
        logic        evicts;
        logic [5:0]  victim;
        block_t      victim_block;
        logic [31:0] exp;
        int          waited;
        repeat (1 + $unsigned($random(seed)) % 2) begin
            @(posedge clock);
            #5;
        end
        resident     = res_valid[a[7:3]] && res_line[a[7:3]] == a[8:3];
        // a waiting write-back of the line answers like a hit while the table has room
        fwd_now      = !resident && wb_valid[a[8:3]] && waiting_writebacks() < `DC_N_MSHR;
        evicts       = !resident && res_valid[a[7:3]] && res_dirty[a[7:3]];
        victim       = res_line[a[7:3]];
        victim_block = gold_block(victim);
        apply_golden(op, size, a, wd, exp);
        check_state_bits(1'b0, 1'b0);
        req_valid = 1'b1;
        req_op    = op;
        req_size  = size;
        req_addr  = {23'b0, a};
        req_wdata = wd;
        @(posedge clock);
        #5;
        req_valid = 1'b0;
        waited    = 1;
        if (resident || fwd_now)
            check_state_bits(1'b0, 1'b1);  // answered in one cycle
        else
            check_state_bits(1'b1, 1'b0);
        while (!resp_valid) begin
            check_state_bits(1'b1, 1'b0);
            @(posedge clock);
            #5;
            waited++;
        end
        check_state_bits(1'b0, 1'b1);
        check_load_data("resp_data", exp, resp_data);
        if (fwd_now) n_fwd++;
        if (evicts) begin
            wb_valid[victim] = 1'b1;  // newer data replaces a waiting copy of the same line
            wb_block[victim] = victim_block;
        end
        res_dirty[a[7:3]] = (resident && res_dirty[a[7:3]]) || op == MEM_WRITE;
        res_valid[a[7:3]] = 1'b1;
        res_line[a[7:3]]  = a[8:3];
    endtask

    task automatic rand_request(input logic [4:0] idx_mask);
        logic [8:0] a;
        mem_op_t    op;
        mem_size_t  size;
        a      = 9'($unsigned($random(seed)));
        a[7:3] = a[7:3] & idx_mask;
        op     = ($random(seed) & 1) ? MEM_WRITE : MEM_READ;
        size   = mem_size_t'(2'($unsigned($random(seed)) % 3));
        do_request(op, size, a, $random(seed));
    endtask

    task automatic report_test(input string name, input int fails_before, input int reqs);
        $display("[%0t] test %s done: %0d requests, %0d failed checks, %0d forwarded so far",
                 $time, name, reqs, n_fail - fails_before, n_fwd);
    endtask

    initial begin
        int         fails_before;
        logic [8:0] a;
        seed        = 35;
        cycle       = 0;
        n_pass      = 0;
        n_fail      = 0;
        n_fwd       = 0;
        reset       = 1'b1;
        req_valid   = 1'b0;
        req_op      = MEM_READ;
        req_size    = BYTE;
        req_addr    = '0;
        req_wdata   = '0;
        hold_enable = 1'b0;
        hold_stores = 1'b0;
        cur_line    = '0;
        for (int i = 0; i < 32; i++) res_valid[i] = 1'b0;
        for (int i = 0; i < 32; i++) res_dirty[i] = 1'b0;
        for (int i = 0; i < 64; i++) wb_valid[i] = 1'b0;
        repeat (3) @(posedge clock);
        #5 reset = 1'b0;
        for (int i = 0; i < 512; i++) gold[i] = u_mem.backing[i / 8][(i % 8) * 8 +: 8];
        cur_pre_block = gold_block(6'd0);

        fails_before = n_fail;
        repeat (10) begin
            check_state_bits(1'b0, 1'b0);
            check_bus_cmd(BUS_NONE, mem_command);
            @(posedge clock);
            #5;
        end
        report_test("reset_idle", fails_before, 0);

        fails_before = n_fail;
        for (int k = 0; k < N_PAIRS; k++) begin
            a = 9'($unsigned($random(seed)));
            do_request(MEM_READ, WORD, a, '0);
            a[2:0] = 3'($unsigned($random(seed)));  // same line, other lane
            do_request(MEM_READ, mem_size_t'(2'($unsigned($random(seed)) % 3)), a, '0);
        end
        report_test("fill_then_hit", fails_before, 2 * N_PAIRS);

        fails_before = n_fail;
        repeat (N_RAND) rand_request(5'b11111);
        report_test("random_mixed", fails_before, N_RAND);

        fails_before = n_fail;
        hold_enable  = 1'b1;
        repeat (N_HOLD) rand_request(5'b00011);  // eight lines over four indexes
        hold_enable  = 1'b0;
        report_test("held_writebacks", fails_before, N_HOLD);

        fails_before = n_fail;
        for (int k = 0; k < N_SWEEP; k++) do_request(MEM_READ, WORD, 9'(k * 4), '0);
        report_test("window_sweep", fails_before, N_SWEEP);

        $display("checks passed: %0d, checks failed: %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
dcache_pkg.sv
dcache_ifs.sv
dcache_ctrl.sv
dcache_lines.sv
dcache_mshr.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv
